// ==== src/eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// CLK cycles per quarter of an SCL period
`define EEPROM_SCL_DIV 2

// byte address width, 2 KB part
`define EEPROM_ADDR_W 11

// device type code, top nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

`endif

// ==== src/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    typedef logic [7:0] i2c_byte_t;

    // commands accepted by the bit engine
    typedef enum logic [1:0] {
        i2c_cmd_start,
        i2c_cmd_write,
        i2c_cmd_read,
        i2c_cmd_stop
    } i2c_cmd_t;

    typedef enum logic [2:0] {
        bit_idle,
        bit_start,
        bit_shift,
        bit_ack,   // ninth bit
        bit_stop
    } i2c_bit_state_t;

endpackage

`default_nettype wire

// ==== src/eeprom_pkg.sv ====
`default_nettype none

`include "eeprom_cfg.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] eeprom_addr_t;
    typedef logic [7:0]                eeprom_data_t;
    typedef logic [7:0]                eeprom_ctrl_byte_t; // code, page, r/w

    typedef enum logic [3:0] {
        seq_idle,
        seq_start,
        seq_ctrl_wr,
        seq_addr,
        seq_data_wr,
        seq_restart,
        seq_ctrl_rd,
        seq_data_rd,
        seq_stop,
        seq_finish
    } eeprom_seq_state_t;

endpackage

`default_nettype wire

// ==== src/i2c_bit_engine.sv ====
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  i2c_cmd_t  cmd,
    input  logic      cmd_valid,
    input  i2c_byte_t tx_byte,
    input  logic      master_ack,
    output logic      done,
    output i2c_byte_t rx_byte,
    output logic      slave_ack,
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda
);

    localparam int Q  = `EEPROM_SCL_DIV;
    localparam int QW = (Q > 1) ? $clog2(Q) : 1;

    i2c_bit_state_t state;
    i2c_cmd_t       cmd_q;
    logic [QW-1:0]  qcnt;
    logic [1:0]     phase;     // quarter within the current bit
    logic [2:0]     bit_cnt;
    logic           tick;
    logic           bit_end;
    i2c_byte_t      shreg;
    logic           sda_bit;
    logic           ack_lvl;
    logic           scl_q;
    logic           oe_q;
    logic           scl_dec;
    logic           oe_dec;

    assign tick    = (qcnt == QW'(Q - 1));
    assign bit_end = tick && (phase == 2'd3);

    // line levels per phase, idle keeps the last ones
    always_comb
    begin
        scl_dec = scl_q;
        oe_dec  = oe_q;
        case (state)
            bit_start:
            begin
                // release first, raise scl, then pull sda low while scl high
                scl_dec = (phase == 2'd0) ? scl_q : (phase != 2'd3);
                oe_dec  = phase[1];
            end
            bit_stop:
            begin
                scl_dec = (phase != 2'd0);
                oe_dec  = !phase[1]; // sda rises while scl high
            end
            bit_shift:
            begin
                scl_dec = (phase == 2'd1) || (phase == 2'd2);
                oe_dec  = (cmd_q == i2c_cmd_write) && !shreg[7];
            end
            bit_ack:
            begin
                scl_dec = (phase == 2'd1) || (phase == 2'd2);
                oe_dec  = (cmd_q == i2c_cmd_read) && !ack_lvl;
            end
            default:
            begin
                scl_dec = scl_q;
                oe_dec  = oe_q;
            end
        endcase
    end

    assign scl     = scl_dec;
    assign sda_oe  = oe_dec;
    assign rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= bit_idle;
            cmd_q <= i2c_cmd_stop;
            qcnt  <= '0;
            phase <= '0;
            done  <= 1'b0;
            scl_q <= 1'b1; // bus idle
            oe_q  <= 1'b0;
        end
        else
        begin
            done  <= 1'b0;
            scl_q <= scl_dec;
            oe_q  <= oe_dec;
            if (state == bit_idle)
            begin
                qcnt  <= '0;
                phase <= '0;
                if (cmd_valid)
                begin
                    cmd_q <= cmd;
                    case (cmd)
                        i2c_cmd_start: state <= bit_start;
                        i2c_cmd_stop:  state <= bit_stop;
                        default:       state <= bit_shift;
                    endcase
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                    phase <= phase + 2'd1;
                if (bit_end)
                begin
                    case (state)
                        bit_shift:
                        begin
                            if (bit_cnt == 3'd0)
                                state <= bit_ack;
                        end
                        default:
                        begin
                            state <= bit_idle;
                            done  <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == bit_idle && cmd_valid)
        begin
            shreg   <= tx_byte;
            bit_cnt <= 3'd7;
            ack_lvl <= master_ack;
        end
        if (tick && phase == 2'd1)
            sda_bit <= sda; // middle of scl high
        if (bit_end && state == bit_shift)
        begin
            shreg   <= {shreg[6:0], sda_bit}; // msb first
            bit_cnt <= bit_cnt - 3'd1;
        end
        if (bit_end && state == bit_ack)
            slave_ack <= sda_bit;
    end

endmodule

`default_nettype wire

// ==== src/eeprom_sequencer.sv ====
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_sequencer
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  eeprom_addr_t wb_adr,
    input  eeprom_data_t wb_dat_w,
    output eeprom_data_t wb_dat_r,
    output logic         wb_ack,
    output logic         wb_err,
    output i2c_cmd_t     cmd,
    output logic         cmd_valid,
    output i2c_byte_t    tx_byte,
    output logic         master_ack,
    input  logic         done,
    input  i2c_byte_t    rx_byte,
    input  logic         slave_ack
);

    eeprom_seq_state_t state;
    eeprom_seq_state_t state_n;
    eeprom_addr_t      adr_q;
    eeprom_data_t      dat_q;
    eeprom_data_t      rd_data;
    eeprom_ctrl_byte_t ctrl_wr;
    eeprom_ctrl_byte_t ctrl_rd;
    logic              we_q;
    logic              nack;       // some written byte went unacknowledged
    logic              wait_low;   // strobe must drop before the next cycle
    logic              bus_req;
    logic              ack_missing;
    logic              issue;
    i2c_cmd_t          cmd_n;
    i2c_byte_t         tx_n;

    assign bus_req = wb_cyc && wb_stb && !wait_low;
    assign ctrl_wr = {`EEPROM_DEV_CODE, adr_q[`EEPROM_ADDR_W-1 -: 3], 1'b0};
    assign ctrl_rd = {`EEPROM_DEV_CODE, adr_q[`EEPROM_ADDR_W-1 -: 3], 1'b1};
    assign ack_missing = done && slave_ack &&
                         (state inside {seq_ctrl_wr, seq_addr, seq_data_wr, seq_ctrl_rd});

    assign master_ack = 1'b1; // single byte reads end with NACK
    assign wb_dat_r   = rd_data;

    always_comb
    begin
        state_n = state;
        issue   = 1'b0;
        cmd_n   = i2c_cmd_stop;
        tx_n    = tx_byte;
        case (state)
            seq_idle:
            begin
                if (bus_req)
                begin
                    state_n = seq_start;
                    issue   = 1'b1;
                    cmd_n   = i2c_cmd_start;
                end
            end
            seq_start, seq_restart:
            begin
                if (done)
                begin
                    state_n = (state == seq_start) ? seq_ctrl_wr : seq_ctrl_rd;
                    issue   = 1'b1;
                    cmd_n   = i2c_cmd_write;
                    tx_n    = (state == seq_start) ? ctrl_wr : ctrl_rd;
                end
            end
            seq_ctrl_wr:
            begin
                if (done && !ack_missing)
                begin
                    state_n = seq_addr;
                    issue   = 1'b1;
                    cmd_n   = i2c_cmd_write;
                    tx_n    = adr_q[7:0];
                end
            end
            seq_addr:
            begin
                if (done && !ack_missing)
                begin
                    state_n = we_q ? seq_data_wr : seq_restart;
                    issue   = 1'b1;
                    cmd_n   = we_q ? i2c_cmd_write : i2c_cmd_start;
                    tx_n    = dat_q;
                end
            end
            seq_ctrl_rd:
            begin
                if (done && !ack_missing)
                begin
                    state_n = seq_data_rd;
                    issue   = 1'b1;
                    cmd_n   = i2c_cmd_read;
                end
            end
            seq_data_wr, seq_data_rd:
            begin
                if (done)
                begin
                    state_n = seq_stop;
                    issue   = 1'b1;
                end
            end
            seq_stop:
            begin
                if (done)
                    state_n = seq_finish;
            end
            default:
                state_n = seq_idle;
        endcase
        if (ack_missing)
        begin
            state_n = seq_stop; // abandon the transfer
            issue   = 1'b1;
            cmd_n   = i2c_cmd_stop;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= seq_idle;
            cmd_valid <= 1'b0;
            wb_ack    <= 1'b0;
            wb_err    <= 1'b0;
            nack      <= 1'b0;
            wait_low  <= 1'b0;
        end
        else
        begin
            state     <= state_n;
            cmd_valid <= issue;
            wb_ack    <= (state == seq_stop) && done && !nack;
            wb_err    <= (state == seq_stop) && done && nack;
            if (state == seq_idle)
                nack <= 1'b0;
            else if (ack_missing)
                nack <= 1'b1;
            if (state == seq_finish)
                wait_low <= wb_stb;
            else if (!wb_stb)
                wait_low <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == seq_idle && bus_req)
        begin
            adr_q <= wb_adr;
            dat_q <= wb_dat_w;
            we_q  <= wb_we;
        end
        if (issue)
        begin
            cmd     <= cmd_n;
            tx_byte <= tx_n;
        end
        if (state == seq_data_rd && done)
            rd_data <= rx_byte;
    end

endmodule

`default_nettype wire

// ==== src/eeprom_ctrl_top.sv ====
`default_nettype none

module eeprom_ctrl_top
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  eeprom_addr_t wb_adr,
    input  eeprom_data_t wb_dat_w,
    output eeprom_data_t wb_dat_r,
    output logic         wb_ack,
    output logic         wb_err,
    output logic         scl,
    output logic         sda_oe,   // high pulls sda low
    input  logic         sda
);

    i2c_cmd_t  cmd;
    logic      cmd_valid;
    i2c_byte_t tx_byte;
    logic      master_ack;
    logic      done;
    i2c_byte_t rx_byte;
    logic      slave_ack;

    eeprom_sequencer sequencer_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .done       (done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack)
    );

    i2c_bit_engine bit_engine_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .done       (done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda        (sda)
    );

endmodule

`default_nettype wire

// ==== bench/eeprom_model.sv ====
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_model
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic sda_oe     // high pulls sda low
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {
        mode_ctrl,
        mode_addr,
        mode_data,
        mode_read
    } model_mode_t;

    eeprom_data_t mem [0:(1 << `EEPROM_ADDR_W) - 1];
    model_mode_t  mode;
    eeprom_addr_t addr;
    i2c_byte_t    shreg;
    i2c_byte_t    out_byte;
    int           bit_cnt;
    logic         active;   // addressed since the last start
    logic         sending;  // byte goes from memory to master

    initial
    begin
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            mem[i] = 8'hff; // erased
        mode     = mode_ctrl;
        addr     = '0;
        shreg    = '0;
        out_byte = 8'hff;
        bit_cnt  = 0;
        active   = 1'b0;
        sending  = 1'b0;
        sda_oe   = 1'b0;
    end

    task automatic take_byte(output logic ack);
        ack = 1'b1;
        case (mode)
            mode_ctrl:
            begin
                if (present && shreg[7:4] == `EEPROM_DEV_CODE)
                begin
                    addr[`EEPROM_ADDR_W-1 -: 3] = shreg[3:1]; // page bits
                    mode = shreg[0] ? mode_read : mode_addr;
                end
                else
                begin
                    ack    = 1'b0;
                    active = 1'b0; // ignore until the next start
                end
            end
            mode_addr:
            begin
                addr[7:0] = shreg;
                mode      = mode_data;
            end
            default:
                mem[addr] = shreg;
        endcase
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b1;
            mode    = mode_ctrl;
            bit_cnt = 0;
            sending = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            active = 1'b0; // stop
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (bit_cnt < 8)
            begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
            else
            begin
                if (sending && sda === 1'b1)
                    active = 1'b0; // master NACK ends the read
                bit_cnt = 0;
            end
        end
    end

    // the model only changes sda while scl is low
    always @(negedge scl)
    begin
        if (!active)
            sda_oe = 1'b0;
        else if (bit_cnt == 8)
        begin
            if (sending)
                sda_oe = 1'b0;
            else
                take_byte(sda_oe);
        end
        else
        begin
            if (bit_cnt == 0)
            begin
                sending  = (mode == mode_read);
                out_byte = mem[addr];
            end
            sda_oe = sending && !out_byte[7 - bit_cnt];
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_eeprom_ctrl.sv ====
`default_nettype none

`include "eeprom_cfg.svh"

module tb_eeprom_ctrl
    import i2c_pkg::*;
    import eeprom_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int Q           = `EEPROM_SCL_DIV;
    localparam int NUM_OPS     = 20;
    localparam int CYCLE_LIMIT = NUM_OPS * (160 * Q + 40) + 20;
    localparam int READ_WAIT   = 156 * Q + 20;
    localparam int IDLE_WAIT   = 4 * Q + 4;   // longer than a start up to its sda fall

    localparam logic [11:0] OP_WRITE   = 12'h0;
    localparam logic [11:0] OP_READ    = 12'h1;
    localparam logic [11:0] OP_ABSENT  = 12'h2;
    localparam logic [11:0] OP_PRESENT = 12'h3;

    logic         CLK;
    logic         RESET;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    eeprom_addr_t wb_adr;
    eeprom_data_t wb_dat_w;
    eeprom_data_t wb_dat_r;
    logic         wb_ack;
    logic         wb_err;
    logic         scl;
    logic         dut_sda_oe;
    logic         model_sda_oe;
    logic         model_present;
    tri1          sda_line;           // open drain with pull-up

    logic [11:0]  golden [0:4*NUM_OPS-1]; // op, address, data, flag
    int           cycle_count = 0;

    assign sda_line = dut_sda_oe   ? 1'b0 : 1'bz;
    assign sda_line = model_sda_oe ? 1'b0 : 1'bz;

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .scl      (scl),
        .sda_oe   (dut_sda_oe),
        .sda      (sda_line)
    );

    eeprom_model eeprom_model_inst (
        .scl     (scl),
        .sda     (sda_line),
        .present (model_present),
        .sda_oe  (model_sda_oe)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #2 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // one Wishbone classic cycle, held until ack or err
    task automatic run_transfer(input logic we, input eeprom_addr_t adr,
                                input eeprom_data_t dat, output logic got_ack,
                                output logic got_err, output eeprom_data_t rdata);
        @(negedge CLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do
            @(negedge CLK);
        while (wb_ack !== 1'b1 && wb_err !== 1'b1);
        got_ack = wb_ack;
        got_err = wb_err;
        rdata   = wb_dat_r;
        // master keeps strobe up through two more edges
        @(negedge CLK);
        check_value(wb_ack, 1'b0, "wb_ack held longer than one cycle");
        check_value(wb_err, 1'b0, "wb_err held longer than one cycle");
        @(negedge CLK);
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        repeat (IDLE_WAIT)
        begin
            @(negedge CLK);
            check_value(scl, 1'b1, "scl after the transfer");
            check_value(dut_sda_oe, 1'b0, "sda_oe after the transfer");
        end
    endtask

    initial
    begin
        logic [11:0]  op;
        eeprom_addr_t adr;
        eeprom_data_t dat;
        logic         flag;
        logic         got_ack;
        logic         got_err;
        eeprom_data_t rdata;

        RESET         = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        model_present = 1'b1;
        $readmemh("bench/eeprom_golden.mem", golden);
        if ($isunknown(golden[4*NUM_OPS-1]))
        begin
            $display("the golden file could not be read or holds too few operations");
            $display("Regression failed");
            $fatal(1);
        end
        repeat (3) @(negedge CLK);
        RESET = 1'b0;

        @(negedge CLK);
        check_value(scl, 1'b1, "scl idle after reset");
        check_value(sda_line, 1'b1, "sda idle after reset");
        check_value(wb_ack, 1'b0, "wb_ack after reset");
        check_value(wb_err, 1'b0, "wb_err after reset");

        // strobe without cyc must start nothing
        wb_stb = 1'b1;
        repeat (READ_WAIT)
        begin
            @(negedge CLK);
            check_value(wb_ack, 1'b0, "wb_ack with wb_cyc low");
            check_value(wb_err, 1'b0, "wb_err with wb_cyc low");
            check_value(scl, 1'b1, "scl with wb_cyc low");
        end
        wb_stb = 1'b0;

        for (int n = 0; n < NUM_OPS; n++)
        begin
            op   = golden[4*n];
            adr  = golden[4*n+1][`EEPROM_ADDR_W-1:0];
            dat  = golden[4*n+2][7:0];
            flag = golden[4*n+3][0];
            case (op)
                OP_WRITE, OP_READ:
                begin
                    run_transfer(op == OP_WRITE, adr, dat, got_ack, got_err, rdata);
                    check_value(got_err, flag, $sformatf("operation %0d wb_err", n));
                    check_value(got_ack, !flag, $sformatf("operation %0d wb_ack", n));
                    if (op == OP_READ && !flag)
                        check_value(rdata, dat, $sformatf("operation %0d read of %h", n, adr));
                end
                OP_ABSENT, OP_PRESENT:
                begin
                    @(negedge CLK);
                    model_present = (op == OP_PRESENT);
                end
                default:
                begin
                    $display("operation %0d in the golden file has an unknown code %h", n, op);
                    $display("Regression failed");
                    $fatal(1);
                end
            endcase
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/eeprom_golden.mem ====
// op: 0 write, 1 read, 2 memory absent, 3 memory present
// columns: op, byte address, data written or expected, 1 when wb_err is expected
0 005 3c 0
0 17a a5 0
0 2ff 01 0
1 005 3c 0
1 17a a5 0
1 2ff 01 0
0 0a0 11 0
0 1a0 22 0
0 7a0 77 0
1 0a0 11 0
1 1a0 22 0
1 7a0 77 0
1 444 ff 0
2 000 00 0
0 010 99 1
1 005 00 1
3 000 00 0
1 010 ff 0
0 010 5a 0
1 010 5a 0

// ==== sources.f ====
+incdir+src
src/i2c_pkg.sv
src/eeprom_pkg.sv
src/i2c_bit_engine.sv
src/eeprom_sequencer.sv
src/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv
